// ==== filelist.f ====
src/commit_pkg.sv
src/exception_checker.sv
src/store_formatter.sv
src/dmem_request.sv
src/commit_ctrl.sv
src/commit_stage.sv
test/tb_clock.sv
test/commit_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module commit_stage_tb \
    --Mdir obj_dir -o commit_stage_sim -f filelist.f

./obj_dir/commit_stage_sim | tee sim.log

if grep -q "^Test passed$" sim.log
then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi

// ==== src/commit_ctrl.sv ====
`timescale 1ns/1ps

module commit_ctrl #(
    parameter commit_pkg::word_t EXC_BASE = 32'hBFC0_0200
) (
    input  logic                  mask,
    input  logic                  slot1_valid,
    input  logic                  slot0_valid,
    input  commit_pkg::op_t       slot1_op,
    input  commit_pkg::op_t       slot0_op,
    input  commit_pkg::word_t     slot1_pc,
    input  commit_pkg::word_t     slot0_pc,
    input  logic                  fault1,
    input  logic                  fault0,
    input  commit_pkg::exc_code_t fault_code1,
    input  commit_pkg::exc_code_t fault_code0,
    input  commit_pkg::word_t     fault_addr1,
    input  commit_pkg::word_t     fault_addr0,
    input  commit_pkg::int_vec_t  ext_int,
    input  commit_pkg::int_vec_t  int_mask,
    input  logic                  int_enable,
    input  logic                  exl,
    output logic                  kill1,
    output logic                  kill0,
    output logic                  mem_sel,
    output logic                  mem_en,
    output logic                  commit1,
    output logic                  commit0,
    output logic                  exception_valid,
    output commit_pkg::exc_code_t exception_code,
    output commit_pkg::word_t     epc,
    output commit_pkg::word_t     bad_vaddr,
    output commit_pkg::word_t     exc_vector,
    output logic                  wait_ex
);

    import commit_pkg::*;

    logic int_pending;
    logic int1;
    logic int0;
    logic exc_on1;
    logic exc_on0;
    logic is_mem1;
    logic is_mem0;

    assign int_pending = int_enable && !exl && ((ext_int & int_mask) != '0);

    // interrupt goes on the oldest live slot
    assign int1 = int_pending && slot1_valid && !kill1;
    assign int0 = int_pending && !slot1_valid && slot0_valid && !kill0;

    assign kill1 = mask;
    assign kill0 = mask || fault1 || int1 || (slot1_valid && slot1_op == OP_ERET);

    assign commit1 = slot1_valid && !kill1 && !fault1 && !int1;
    assign commit0 = slot0_valid && !kill0 && !fault0 && !int0;

    assign exc_on1 = int1 || fault1;
    assign exc_on0 = int0 || fault0;
    assign exception_valid = exc_on1 || exc_on0;

    // slot 1 wins, interrupt before fault
    always_comb
    begin
        if (int1)
            exception_code = EXC_INT;
        else if (fault1)
            exception_code = fault_code1;
        else if (int0)
            exception_code = EXC_INT;
        else
            exception_code = fault_code0;
    end

    assign epc = exc_on1 ? slot1_pc : slot0_pc;

    always_comb
    begin
        if (int1)
            bad_vaddr = '0;
        else if (fault1)
            bad_vaddr = fault_addr1;
        else if (int0)
            bad_vaddr = '0;
        else
            bad_vaddr = fault_addr0;
    end

    assign exc_vector = EXC_BASE + VEC_OFFSET;

    assign is_mem1 = (slot1_op == OP_LOAD) || (slot1_op == OP_STORE);
    assign is_mem0 = (slot0_op == OP_LOAD) || (slot0_op == OP_STORE);
    assign mem_sel = is_mem1;
    assign mem_en  = mem_sel ? (commit1 && is_mem1) : (commit0 && is_mem0);

    assign wait_ex = ((commit1 && slot1_op == OP_WAIT) || (commit0 && slot0_op == OP_WAIT))
                     && !exception_valid;

    always_comb
    begin
        if (exception_valid)
        begin
            assert (exc_on1 ? !commit1 : !commit0)
                else $error("excepting slot also commits");
        end
    end

endmodule

// ==== src/commit_pkg.sv ====
package commit_pkg;

    // data word, also used for pc and address
    typedef logic [31:0] word_t;

    typedef logic [2:0] op_t;
    typedef logic [1:0] mem_size_t;
    typedef logic [3:0] byte_en_t;

    // cause.ExcCode
    typedef logic [4:0] exc_code_t;

    // external interrupt lines and their mask
    typedef logic [5:0] int_vec_t;

    // instruction kinds
    localparam op_t OP_NONE    = 3'd0;
    localparam op_t OP_ALU     = 3'd1;
    localparam op_t OP_LOAD    = 3'd2;
    localparam op_t OP_STORE   = 3'd3;
    localparam op_t OP_SYSCALL = 3'd4;
    localparam op_t OP_BREAK   = 3'd5;
    localparam op_t OP_ERET    = 3'd6;
    localparam op_t OP_WAIT    = 3'd7;

    // access sizes
    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    // exception codes
    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_SYS  = 5'd8;
    localparam exc_code_t EXC_BP   = 5'd9;
    localparam exc_code_t EXC_OV   = 5'd12;

    // general exception entry, relative to the vector base
    localparam word_t VEC_OFFSET = 32'h0000_0180;

endpackage

// ==== src/commit_stage.sv ====
`timescale 1ns/1ps

module commit_stage #(
    parameter commit_pkg::word_t EXC_BASE = 32'hBFC0_0200
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mask,
    input  logic                  stall,
    input  logic                  slot1_valid,
    input  commit_pkg::op_t       slot1_op,
    input  commit_pkg::word_t     slot1_pc,
    input  commit_pkg::word_t     slot1_addr,
    input  commit_pkg::mem_size_t slot1_size,
    input  commit_pkg::word_t     slot1_wdata,
    input  logic                  slot1_overflow,
    input  logic                  slot0_valid,
    input  commit_pkg::op_t       slot0_op,
    input  commit_pkg::word_t     slot0_pc,
    input  commit_pkg::word_t     slot0_addr,
    input  commit_pkg::mem_size_t slot0_size,
    input  commit_pkg::word_t     slot0_wdata,
    input  logic                  slot0_overflow,
    input  commit_pkg::int_vec_t  ext_int,
    input  commit_pkg::int_vec_t  int_mask,
    input  logic                  int_enable,
    input  logic                  exl,
    input  logic                  dmem_addr_ok,
    output logic                  commit1,
    output logic                  commit0,
    output logic                  exception_valid,
    output commit_pkg::exc_code_t exception_code,
    output commit_pkg::word_t     epc,
    output commit_pkg::word_t     bad_vaddr,
    output commit_pkg::word_t     exc_vector,
    output logic                  wait_ex,
    output logic                  dmem_req,
    output commit_pkg::word_t     dmem_addr,
    output commit_pkg::mem_size_t dmem_size,
    output logic                  dmem_wt,
    output commit_pkg::word_t     dmem_wd,
    output commit_pkg::byte_en_t  dmem_byte_en,
    output logic                  mem_done
);

    import commit_pkg::*;

    logic      kill1;
    logic      kill0;
    logic      fault1;
    logic      fault0;
    exc_code_t fault_code1;
    exc_code_t fault_code0;
    word_t     fault_addr1;
    word_t     fault_addr0;
    logic      mem_sel;
    logic      mem_en;

    exception_checker chk1 (
        .clk        (clk),
        .rst        (rst),
        .kill       (kill1),
        .valid      (slot1_valid),
        .op         (slot1_op),
        .addr       (slot1_addr),
        .size       (slot1_size),
        .overflow   (slot1_overflow),
        .fault      (fault1),
        .fault_code (fault_code1),
        .fault_addr (fault_addr1)
    );

    exception_checker chk0 (
        .clk        (clk),
        .rst        (rst),
        .kill       (kill0),
        .valid      (slot0_valid),
        .op         (slot0_op),
        .addr       (slot0_addr),
        .size       (slot0_size),
        .overflow   (slot0_overflow),
        .fault      (fault0),
        .fault_code (fault_code0),
        .fault_addr (fault_addr0)
    );

    commit_ctrl #(
        .EXC_BASE (EXC_BASE)
    ) ctrl (
        .mask            (mask),
        .slot1_valid     (slot1_valid),
        .slot0_valid     (slot0_valid),
        .slot1_op        (slot1_op),
        .slot0_op        (slot0_op),
        .slot1_pc        (slot1_pc),
        .slot0_pc        (slot0_pc),
        .fault1          (fault1),
        .fault0          (fault0),
        .fault_code1     (fault_code1),
        .fault_code0     (fault_code0),
        .fault_addr1     (fault_addr1),
        .fault_addr0     (fault_addr0),
        .ext_int         (ext_int),
        .int_mask        (int_mask),
        .int_enable      (int_enable),
        .exl             (exl),
        .kill1           (kill1),
        .kill0           (kill0),
        .mem_sel         (mem_sel),
        .mem_en          (mem_en),
        .commit1         (commit1),
        .commit0         (commit0),
        .exception_valid (exception_valid),
        .exception_code  (exception_code),
        .epc             (epc),
        .bad_vaddr       (bad_vaddr),
        .exc_vector      (exc_vector),
        .wait_ex         (wait_ex)
    );

    store_formatter fmt (
        .clk          (clk),
        .mem_sel      (mem_sel),
        .slot1_op     (slot1_op),
        .slot0_op     (slot0_op),
        .slot1_addr   (slot1_addr),
        .slot0_addr   (slot0_addr),
        .slot1_size   (slot1_size),
        .slot0_size   (slot0_size),
        .slot1_wdata  (slot1_wdata),
        .slot0_wdata  (slot0_wdata),
        .dmem_addr    (dmem_addr),
        .dmem_size    (dmem_size),
        .dmem_wt      (dmem_wt),
        .dmem_wd      (dmem_wd),
        .dmem_byte_en (dmem_byte_en)
    );

    dmem_request req (
        .clk          (clk),
        .rst          (rst),
        .mask         (mask),
        .stall        (stall),
        .mem_en       (mem_en),
        .dmem_addr_ok (dmem_addr_ok),
        .dmem_req     (dmem_req),
        .mem_done     (mem_done)
    );

endmodule

// ==== src/dmem_request.sv ====
`timescale 1ns/1ps

module dmem_request (
    input  logic clk,
    input  logic rst,
    input  logic mask,
    input  logic stall,
    input  logic mem_en,
    input  logic dmem_addr_ok,
    output logic dmem_req,
    output logic mem_done
);

    // address accepted earlier in this stall
    logic addr_ok_held;

    always_ff @(posedge clk)
    begin
        if (rst || mask || !stall)
        begin
            addr_ok_held <= 1'b0;
        end
        else if (dmem_addr_ok)
        begin
            addr_ok_held <= 1'b1;
        end
    end

    assign dmem_req = mem_en && !addr_ok_held;

    // nothing to wait for, accepted now, or accepted before
    assign mem_done = !mem_en || dmem_addr_ok || addr_ok_held;

    // no second request for the same access while stalled
    assert property (@(posedge clk) disable iff (rst)
        (stall && dmem_addr_ok && !mask) ##1 stall |-> !dmem_req)
        else $error("request repeated after acceptance under stall");

endmodule

// ==== src/exception_checker.sv ====
`timescale 1ns/1ps

module exception_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  kill,
    input  logic                  valid,
    input  commit_pkg::op_t       op,
    input  commit_pkg::word_t     addr,
    input  commit_pkg::mem_size_t size,
    input  logic                  overflow,
    output logic                  fault,
    output commit_pkg::exc_code_t fault_code,
    output commit_pkg::word_t     fault_addr
);

    import commit_pkg::*;

    logic live;
    logic misaligned;

    assign live = valid && !kill;

    // alignment by access size
    always_comb
    begin
        case (size)
            SIZE_BYTE: misaligned = 1'b0;
            SIZE_HALF: misaligned = addr[0];
            default:   misaligned = (addr[1:0] != 2'b00);
        endcase
    end

    always_comb
    begin
        fault      = 1'b0;
        fault_code = EXC_INT;
        fault_addr = '0;
        if (live)
        begin
            case (op)
                OP_ALU:
                begin
                    fault      = overflow;
                    fault_code = EXC_OV;
                end
                OP_SYSCALL:
                begin
                    fault      = 1'b1;
                    fault_code = EXC_SYS;
                end
                OP_BREAK:
                begin
                    fault      = 1'b1;
                    fault_code = EXC_BP;
                end
                OP_LOAD:
                begin
                    fault      = misaligned;
                    fault_code = EXC_ADEL;
                    fault_addr = misaligned ? addr : '0;
                end
                OP_STORE:
                begin
                    fault      = misaligned;
                    fault_code = EXC_ADES;
                    fault_addr = misaligned ? addr : '0;
                end
                default:
                begin
                    fault = 1'b0;
                end
            endcase
        end
    end

    // a killed slot never reports
    assert property (@(posedge clk) disable iff (rst) kill |-> !fault)
        else $error("fault raised on killed slot");

endmodule

// ==== src/store_formatter.sv ====
`timescale 1ns/1ps

module store_formatter (
    input  logic                  clk,
    input  logic                  mem_sel,
    input  commit_pkg::op_t       slot1_op,
    input  commit_pkg::op_t       slot0_op,
    input  commit_pkg::word_t     slot1_addr,
    input  commit_pkg::word_t     slot0_addr,
    input  commit_pkg::mem_size_t slot1_size,
    input  commit_pkg::mem_size_t slot0_size,
    input  commit_pkg::word_t     slot1_wdata,
    input  commit_pkg::word_t     slot0_wdata,
    output commit_pkg::word_t     dmem_addr,
    output commit_pkg::mem_size_t dmem_size,
    output logic                  dmem_wt,
    output commit_pkg::word_t     dmem_wd,
    output commit_pkg::byte_en_t  dmem_byte_en
);

    import commit_pkg::*;

    op_t      sel_op;
    word_t    sel_wdata;
    byte_en_t lanes;

    // mem_sel high picks slot 1
    assign sel_op    = mem_sel ? slot1_op : slot0_op;
    assign sel_wdata = mem_sel ? slot1_wdata : slot0_wdata;
    assign dmem_addr = mem_sel ? slot1_addr : slot0_addr;
    assign dmem_size = mem_sel ? slot1_size : slot0_size;
    assign dmem_wt   = (sel_op == OP_STORE);

    // replicate into every lane, enable only the addressed ones
    always_comb
    begin
        case (dmem_size)
            SIZE_BYTE:
            begin
                dmem_wd = {4{sel_wdata[7:0]}};
                lanes   = 4'b0001 << dmem_addr[1:0];
            end
            SIZE_HALF:
            begin
                dmem_wd = {2{sel_wdata[15:0]}};
                lanes   = dmem_addr[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                dmem_wd = sel_wdata;
                lanes   = 4'b1111;
            end
        endcase
    end

    assign dmem_byte_en = dmem_wt ? lanes : '0;

    assert property (@(posedge clk) dmem_wt |-> (dmem_byte_en != '0))
        else $error("store with no byte lanes enabled");

endmodule

// ==== test/commit_stage_tb.sv ====
`timescale 1ns/1ps

module commit_stage_tb;

    import commit_pkg::*;

    // 0xBFC00200 base plus the general exception offset
    localparam word_t EXP_VECTOR = 32'hBFC0_0380;
    localparam int    WAIT_LIMIT = 20;

    logic      clk;
    logic      rst;
    logic      mask;
    logic      stall;
    logic      slot1_valid;
    op_t       slot1_op;
    word_t     slot1_pc;
    word_t     slot1_addr;
    mem_size_t slot1_size;
    word_t     slot1_wdata;
    logic      slot1_overflow;
    logic      slot0_valid;
    op_t       slot0_op;
    word_t     slot0_pc;
    word_t     slot0_addr;
    mem_size_t slot0_size;
    word_t     slot0_wdata;
    logic      slot0_overflow;
    int_vec_t  ext_int;
    int_vec_t  int_mask;
    logic      int_enable;
    logic      exl;
    logic      dmem_addr_ok;
    logic      commit1;
    logic      commit0;
    logic      exception_valid;
    exc_code_t exception_code;
    word_t     epc;
    word_t     bad_vaddr;
    word_t     exc_vector;
    logic      wait_ex;
    logic      dmem_req;
    word_t     dmem_addr;
    mem_size_t dmem_size;
    logic      dmem_wt;
    word_t     dmem_wd;
    byte_en_t  dmem_byte_en;
    logic      mem_done;

    integer seed;
    int     error_count;
    int     timeout_count;

    tb_clock #(.PERIOD(20)) clock_gen (.clk(clk));

    commit_stage #(.EXC_BASE(32'hBFC0_0200)) uut (
        .clk             (clk),
        .rst             (rst),
        .mask            (mask),
        .stall           (stall),
        .slot1_valid     (slot1_valid),
        .slot1_op        (slot1_op),
        .slot1_pc        (slot1_pc),
        .slot1_addr      (slot1_addr),
        .slot1_size      (slot1_size),
        .slot1_wdata     (slot1_wdata),
        .slot1_overflow  (slot1_overflow),
        .slot0_valid     (slot0_valid),
        .slot0_op        (slot0_op),
        .slot0_pc        (slot0_pc),
        .slot0_addr      (slot0_addr),
        .slot0_size      (slot0_size),
        .slot0_wdata     (slot0_wdata),
        .slot0_overflow  (slot0_overflow),
        .ext_int         (ext_int),
        .int_mask        (int_mask),
        .int_enable      (int_enable),
        .exl             (exl),
        .dmem_addr_ok    (dmem_addr_ok),
        .commit1         (commit1),
        .commit0         (commit0),
        .exception_valid (exception_valid),
        .exception_code  (exception_code),
        .epc             (epc),
        .bad_vaddr       (bad_vaddr),
        .exc_vector      (exc_vector),
        .wait_ex         (wait_ex),
        .dmem_req        (dmem_req),
        .dmem_addr       (dmem_addr),
        .dmem_size       (dmem_size),
        .dmem_wt         (dmem_wt),
        .dmem_wd         (dmem_wd),
        .dmem_byte_en    (dmem_byte_en),
        .mem_done        (mem_done)
    );

    task automatic compare_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected)
        begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_code(input string name, input exc_code_t actual,
                                input exc_code_t expected);
        if (actual !== expected)
        begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_be(input string name, input byte_en_t actual,
                              input byte_en_t expected);
        if (actual !== expected)
        begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_size(input string name, input mem_size_t actual,
                                input mem_size_t expected);
        if (actual !== expected)
        begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic next_fall();
        @(negedge clk);
    endtask

    // half way through the low phase, well clear of both edges
    task automatic settle();
        #5;
    endtask

    task automatic clear_inputs();
        mask           = 1'b0;
        stall          = 1'b0;
        slot1_valid    = 1'b0;
        slot1_op       = OP_NONE;
        slot1_pc       = 32'h0;
        slot1_addr     = 32'h0;
        slot1_size     = SIZE_WORD;
        slot1_wdata    = 32'h0;
        slot1_overflow = 1'b0;
        slot0_valid    = 1'b0;
        slot0_op       = OP_NONE;
        slot0_pc       = 32'h0;
        slot0_addr     = 32'h0;
        slot0_size     = SIZE_WORD;
        slot0_wdata    = 32'h0;
        slot0_overflow = 1'b0;
        ext_int        = 6'b0;
        int_mask       = 6'b0;
        int_enable     = 1'b0;
        exl            = 1'b0;
        dmem_addr_ok   = 1'b0;
    endtask

    task automatic set_slot1(input logic v, input op_t op, input word_t pc, input word_t addr,
                             input mem_size_t size, input word_t wdata, input logic ovf);
        slot1_valid    = v;
        slot1_op       = op;
        slot1_pc       = pc;
        slot1_addr     = addr;
        slot1_size     = size;
        slot1_wdata    = wdata;
        slot1_overflow = ovf;
    endtask

    task automatic set_slot0(input logic v, input op_t op, input word_t pc, input word_t addr,
                             input mem_size_t size, input word_t wdata, input logic ovf);
        slot0_valid    = v;
        slot0_op       = op;
        slot0_pc       = pc;
        slot0_addr     = addr;
        slot0_size     = size;
        slot0_wdata    = wdata;
        slot0_overflow = ovf;
    endtask

    task automatic wait_req(input logic expected);
        int n;
        n = 0;
        while (dmem_req !== expected && n < WAIT_LIMIT)
        begin
            next_fall();
            settle();
            n++;
        end
        if (dmem_req !== expected)
        begin
            $display("timeout: dmem_req did not reach %0b within %0d cycles", expected, n);
            timeout_count++;
        end
    endtask

    task automatic store_case(input mem_size_t size, input word_t addr, input word_t data,
                              input word_t exp_wd, input byte_en_t exp_be);
        next_fall();
        clear_inputs();
        set_slot1(1'b1, OP_ALU, 32'h8000_0100, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        set_slot0(1'b1, OP_STORE, 32'h8000_0104, addr, size, data, 1'b0);
        settle();
        compare_bit("commit0", commit0, 1'b1);
        compare_bit("dmem_req", dmem_req, 1'b1);
        compare_bit("dmem_wt", dmem_wt, 1'b1);
        compare_word("dmem_addr", dmem_addr, addr);
        compare_size("dmem_size", dmem_size, size);
        compare_word("dmem_wd", dmem_wd, exp_wd);
        compare_be("dmem_byte_en", dmem_byte_en, exp_be);
    endtask

    task automatic format_stores();
        word_t data;
        data = $random(seed);
        store_case(SIZE_BYTE, 32'h0000_2000, data, {4{data[7:0]}}, 4'b0001);
        data = $random(seed);
        store_case(SIZE_BYTE, 32'h0000_2001, data, {4{data[7:0]}}, 4'b0010);
        data = $random(seed);
        store_case(SIZE_BYTE, 32'h0000_2002, data, {4{data[7:0]}}, 4'b0100);
        data = $random(seed);
        store_case(SIZE_BYTE, 32'h0000_2003, data, {4{data[7:0]}}, 4'b1000);
        data = $random(seed);
        store_case(SIZE_HALF, 32'h0000_2000, data, {2{data[15:0]}}, 4'b0011);
        data = $random(seed);
        store_case(SIZE_HALF, 32'h0000_2002, data, {2{data[15:0]}}, 4'b1100);
        data = $random(seed);
        store_case(SIZE_WORD, 32'h0000_2004, data, data, 4'b1111);
        // a load asks for memory but writes no lanes
        next_fall();
        set_slot0(1'b1, OP_LOAD, 32'h8000_0104, 32'h0000_2008, SIZE_WORD, data, 1'b0);
        settle();
        compare_bit("dmem_req", dmem_req, 1'b1);
        compare_bit("dmem_wt", dmem_wt, 1'b0);
        compare_be("dmem_byte_en", dmem_byte_en, 4'b0000);
        compare_word("dmem_addr", dmem_addr, 32'h0000_2008);
        compare_size("dmem_size", dmem_size, SIZE_WORD);
    endtask

    task automatic slot1_fault_case(input op_t op, input word_t addr, input mem_size_t size,
                                    input logic ovf, input exc_code_t exp_code,
                                    input logic addr_err);
        next_fall();
        clear_inputs();
        set_slot1(1'b1, op, 32'h8000_0200, addr, size, 32'h0, ovf);
        set_slot0(1'b1, OP_STORE, 32'h8000_0204, 32'h0000_3000, SIZE_WORD, 32'h1234_5678, 1'b0);
        settle();
        compare_bit("exception_valid", exception_valid, 1'b1);
        compare_code("exception_code", exception_code, exp_code);
        compare_word("epc", epc, 32'h8000_0200);
        if (addr_err)
        begin
            compare_word("bad_vaddr", bad_vaddr, addr);
        end
        compare_bit("commit1", commit1, 1'b0);
        compare_bit("commit0", commit0, 1'b0);
        compare_bit("dmem_req", dmem_req, 1'b0);
        compare_word("exc_vector", exc_vector, EXP_VECTOR);
    endtask

    task automatic raise_instr_exceptions();
        slot1_fault_case(OP_ALU, 32'h0, SIZE_WORD, 1'b1, EXC_OV, 1'b0);
        slot1_fault_case(OP_SYSCALL, 32'h0, SIZE_WORD, 1'b0, EXC_SYS, 1'b0);
        slot1_fault_case(OP_BREAK, 32'h0, SIZE_WORD, 1'b0, EXC_BP, 1'b0);
        slot1_fault_case(OP_LOAD, 32'h0000_3002, SIZE_WORD, 1'b0, EXC_ADEL, 1'b1);
        slot1_fault_case(OP_STORE, 32'h0000_3001, SIZE_HALF, 1'b0, EXC_ADES, 1'b1);
        // younger slot faults alone, the older one still retires
        next_fall();
        clear_inputs();
        set_slot1(1'b1, OP_ALU, 32'h8000_0200, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        set_slot0(1'b1, OP_BREAK, 32'h8000_0204, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        settle();
        compare_bit("commit1", commit1, 1'b1);
        compare_bit("commit0", commit0, 1'b0);
        compare_bit("exception_valid", exception_valid, 1'b1);
        compare_code("exception_code", exception_code, EXC_BP);
        compare_word("epc", epc, 32'h8000_0204);
    endtask

    task automatic interrupt_case(input logic en, input logic exl_v, input int_vec_t lines,
                                  input int_vec_t enables, input logic slot1_v,
                                  input logic exp_int);
        next_fall();
        clear_inputs();
        set_slot1(slot1_v, OP_ALU, 32'h8000_0300, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        set_slot0(1'b1, OP_ALU, 32'h8000_0304, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        int_enable = en;
        exl        = exl_v;
        ext_int    = lines;
        int_mask   = enables;
        settle();
        compare_bit("exception_valid", exception_valid, exp_int);
        compare_word("exc_vector", exc_vector, EXP_VECTOR);
        compare_bit("commit1", commit1, slot1_v && !exp_int);
        compare_bit("commit0", commit0, !exp_int);
        if (exp_int)
        begin
            compare_code("exception_code", exception_code, EXC_INT);
            compare_word("epc", epc, slot1_v ? 32'h8000_0300 : 32'h8000_0304);
        end
    endtask

    task automatic take_interrupts();
        interrupt_case(1'b1, 1'b0, 6'b000100, 6'b000100, 1'b1, 1'b1);
        interrupt_case(1'b0, 1'b0, 6'b000100, 6'b000100, 1'b1, 1'b0);
        interrupt_case(1'b1, 1'b1, 6'b000100, 6'b000100, 1'b1, 1'b0);
        interrupt_case(1'b1, 1'b0, 6'b000100, 6'b111011, 1'b1, 1'b0);
        interrupt_case(1'b1, 1'b0, 6'b100001, 6'b100000, 1'b0, 1'b1);
    endtask

    task automatic stall_handshake();
        word_t data;
        data = $random(seed);
        next_fall();
        clear_inputs();
        set_slot1(1'b1, OP_ALU, 32'h8000_0400, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        set_slot0(1'b1, OP_STORE, 32'h8000_0404, 32'h0000_4000, SIZE_WORD, data, 1'b0);
        stall = 1'b1;
        settle();
        wait_req(1'b1);
        compare_bit("mem_done", mem_done, 1'b0);
        next_fall();
        dmem_addr_ok = 1'b1;
        settle();
        compare_bit("mem_done", mem_done, 1'b1);
        next_fall();
        dmem_addr_ok = 1'b0;
        settle();
        compare_bit("dmem_req", dmem_req, 1'b0);
        compare_bit("mem_done", mem_done, 1'b1);
        next_fall();
        settle();
        compare_bit("dmem_req", dmem_req, 1'b0);
        // same store again once the pipeline moves
        next_fall();
        stall = 1'b0;
        settle();
        wait_req(1'b1);
        compare_word("dmem_addr", dmem_addr, 32'h0000_4000);
        compare_size("dmem_size", dmem_size, SIZE_WORD);
        compare_word("dmem_wd", dmem_wd, data);
        compare_bit("mem_done", mem_done, 1'b0);
    endtask

    task automatic eret_and_wait();
        next_fall();
        clear_inputs();
        set_slot1(1'b1, OP_ERET, 32'h8000_0500, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        set_slot0(1'b1, OP_ALU, 32'h8000_0504, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        settle();
        compare_bit("commit1", commit1, 1'b1);
        compare_bit("commit0", commit0, 1'b0);
        compare_bit("exception_valid", exception_valid, 1'b0);
        next_fall();
        set_slot1(1'b1, OP_ALU, 32'h8000_0500, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        set_slot0(1'b1, OP_WAIT, 32'h8000_0504, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        settle();
        compare_bit("commit0", commit0, 1'b1);
        compare_bit("wait_ex", wait_ex, 1'b1);
        next_fall();
        set_slot1(1'b1, OP_BREAK, 32'h8000_0500, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        settle();
        compare_bit("wait_ex", wait_ex, 1'b0);
        compare_bit("exception_valid", exception_valid, 1'b1);
        // wait retires in the older slot while the younger one faults
        next_fall();
        set_slot1(1'b1, OP_WAIT, 32'h8000_0500, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        set_slot0(1'b1, OP_SYSCALL, 32'h8000_0504, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        settle();
        compare_bit("commit1", commit1, 1'b1);
        compare_bit("exception_valid", exception_valid, 1'b1);
        compare_bit("wait_ex", wait_ex, 1'b0);
    endtask

    task automatic flush_pair();
        next_fall();
        clear_inputs();
        mask = 1'b1;
        set_slot1(1'b1, OP_STORE, 32'h8000_0600, 32'h0000_5000, SIZE_WORD, 32'h0, 1'b0);
        set_slot0(1'b1, OP_SYSCALL, 32'h8000_0604, 32'h0, SIZE_WORD, 32'h0, 1'b0);
        int_enable = 1'b1;
        ext_int    = 6'b000001;
        int_mask   = 6'b000001;
        settle();
        compare_bit("commit1", commit1, 1'b0);
        compare_bit("commit0", commit0, 1'b0);
        compare_bit("exception_valid", exception_valid, 1'b0);
        compare_bit("dmem_req", dmem_req, 1'b0);
        next_fall();
        set_slot1(1'b1, OP_ALU, 32'h8000_0600, 32'h0, SIZE_WORD, 32'h0, 1'b1);
        set_slot0(1'b1, OP_LOAD, 32'h8000_0604, 32'h0000_5003, SIZE_WORD, 32'h0, 1'b0);
        settle();
        compare_bit("commit1", commit1, 1'b0);
        compare_bit("commit0", commit0, 1'b0);
        compare_bit("exception_valid", exception_valid, 1'b0);
        compare_bit("dmem_req", dmem_req, 1'b0);
    endtask

    initial
    begin
        seed          = 32'h4518_01c8;
        error_count   = 0;
        timeout_count = 0;
        rst           = 1'b1;
        clear_inputs();
        repeat (2) @(posedge clk);
        next_fall();
        rst = 1'b0;
        settle();
        // idle pair after reset
        compare_bit("dmem_req", dmem_req, 1'b0);
        compare_bit("exception_valid", exception_valid, 1'b0);
        compare_bit("wait_ex", wait_ex, 1'b0);

        format_stores();
        raise_instr_exceptions();
        take_interrupts();
        stall_handshake();
        eret_and_wait();
        flush_pair();

        $display("errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule
